/* verilog/i2c_tgt_pkg.sv */
/*
 * I2C target shared definitions
 * Device address, register depth, the byte types used across the
 * target and the protocol engine state encoding
 */

package i2c_tgt_pkg;

	// **************************************************************************
	// Vector types
	// **************************************************************************
	typedef logic [7:0] byte_t;
	typedef logic [6:0] dev_addr_t;
	// Pointer stays 8 bits wide so values past the bank are visible
	typedef logic [7:0] ptr_t;
	typedef logic [3:0] reg_idx_t;

	// **************************************************************************
	// Constants
	// **************************************************************************
	localparam dev_addr_t TGT_ADDR = 7'h10;
	localparam int unsigned REG_DEPTH = 16;
	// Returned when the pointer is outside the bank
	localparam byte_t RD_FILL = 8'hff;

	// Protocol engine states
	typedef enum logic [3:0]
	{
		ST_IDLE,
		ST_DEV_ADDR,
		ST_DEV_ACK,
		ST_PTR,
		ST_PTR_ACK,
		ST_WR_DATA,
		ST_WR_ACK,
		ST_RD_DATA,
		ST_RD_ACK
	} tgt_state_t;

endpackage

/* verilog/i2c_line_sync.sv */
/*
 * I2C line synchronizer
 * Brings bus_clk and bus_dat into the scl domain through two flops each
 * and produces single-cycle pulses for clock edges, start and stop
 */

`timescale 1ns/1ps

module i2c_line_sync
(
	input  logic scl,
	input  logic rst_n,
	input  logic bus_clk,
	input  logic bus_dat,
	output logic clk_rise,
	output logic clk_fall,
	output logic start_det,
	output logic stop_det,
	output logic dat_s
);

	logic [1:0] clk_sync;
	logic [1:0] dat_sync;
	logic       clk_p;
	logic       dat_p;
	logic       clk_s;

	assign clk_s = clk_sync[1];
	assign dat_s = dat_sync[1];

	// Lines idle high, so reset to one to avoid a false start
	always_ff @(posedge scl or negedge rst_n)
	begin
		if (!rst_n)
		begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_p    <= 1'b1;
			dat_p    <= 1'b1;
		end
		else
		begin
			clk_sync <= {clk_sync[0], bus_clk};
			dat_sync <= {dat_sync[0], bus_dat};
			clk_p    <= clk_s;
			dat_p    <= dat_s;
		end
	end

	// **************************************************************************
	// Edge and condition pulses, one cycle each
	// **************************************************************************
	always_ff @(posedge scl or negedge rst_n)
	begin
		if (!rst_n)
		begin
			clk_rise  <= 1'b0;
			clk_fall  <= 1'b0;
			start_det <= 1'b0;
			stop_det  <= 1'b0;
		end
		else
		begin
			clk_rise  <= clk_s & ~clk_p;
			clk_fall  <= ~clk_s & clk_p;
			// Data moves while the clock stays high
			start_det <= clk_s & clk_p & dat_p & ~dat_s;
			stop_det  <= clk_s & clk_p & ~dat_p & dat_s;
		end
	end

endmodule

/* verilog/i2c_tgt_engine.sv */
/*
 * I2C target protocol engine
 * Receives the device address, register pointer and write bytes,
 * shifts out read bytes and drives ACK by pulling the data line low.
 * Bits are taken on the clock rise, the line changes after the fall
 */

`timescale 1ns/1ps

module i2c_tgt_engine
	import i2c_tgt_pkg::*;
(
	input  logic     scl,
	input  logic     rst_n,
	input  logic     clk_rise,
	input  logic     clk_fall,
	input  logic     start_det,
	input  logic     stop_det,
	input  logic     dat_s,
	input  byte_t    bus_rdata,
	output logic     bus_dat_oe,
	output reg_idx_t bus_idx,
	output logic     bus_we,
	output byte_t    bus_wdata,
	output logic     bus_busy
);

	tgt_state_t state;
	byte_t      rx_shift;
	byte_t      tx_shift;
	logic [3:0] bit_cnt;
	logic       rd_mode;
	logic       host_nack;
	ptr_t       ptr;
	logic       byte_done;
	logic       ptr_ok;
	logic       rx_state;
	logic       tx_load;
	byte_t      rd_byte;

	assign byte_done = (bit_cnt == 4'd8);
	assign ptr_ok    = (ptr < ptr_t'(REG_DEPTH));
	assign rx_state  = (state == ST_DEV_ADDR) || (state == ST_PTR) || (state == ST_WR_DATA);

	// Next read byte, fill value once the pointer runs off the bank
	assign rd_byte = ptr_ok ? bus_rdata : RD_FILL;
	assign tx_load = ((state == ST_DEV_ACK) && rd_mode) || ((state == ST_RD_ACK) && !host_nack);

	// **************************************************************************
	// Register bank port
	// **************************************************************************
	assign bus_idx   = reg_idx_t'(ptr);
	assign bus_wdata = rx_shift;
	// Write lands in the same cycle the pointer advances
	assign bus_we    = clk_fall && (state == ST_WR_DATA) && byte_done && ptr_ok;
	assign bus_busy  = (state != ST_IDLE);

	// **************************************************************************
	// Protocol FSM
	// **************************************************************************
	always_ff @(posedge scl or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= ST_IDLE;
			bit_cnt    <= 4'd0;
			rd_mode    <= 1'b0;
			host_nack  <= 1'b0;
			ptr        <= '0;
			bus_dat_oe <= 1'b0;
		end
		else if (start_det)
		begin
			// Also covers a repeated start
			state      <= ST_DEV_ADDR;
			bit_cnt    <= 4'd0;
			bus_dat_oe <= 1'b0;
		end
		else if (stop_det)
		begin
			state      <= ST_IDLE;
			bus_dat_oe <= 1'b0;
		end
		else if (clk_rise)
		begin
			if (rx_state || (state == ST_RD_DATA))
				bit_cnt <= bit_cnt + 4'd1;
			// Controller answer after a read byte
			if (state == ST_RD_ACK)
				host_nack <= dat_s;
		end
		else if (clk_fall)
		begin
			case (state)
				ST_DEV_ADDR:
					if (byte_done)
					begin
						bit_cnt <= 4'd0;
						if (rx_shift[7:1] == TGT_ADDR)
						begin
							state      <= ST_DEV_ACK;
							rd_mode    <= rx_shift[0];
							bus_dat_oe <= 1'b1;
						end
						else
							state <= ST_IDLE;
					end
				ST_DEV_ACK:
					if (rd_mode)
					begin
						state      <= ST_RD_DATA;
						bus_dat_oe <= ~rd_byte[7];
					end
					else
					begin
						state      <= ST_PTR;
						bus_dat_oe <= 1'b0;
					end
				ST_PTR:
					if (byte_done)
					begin
						bit_cnt    <= 4'd0;
						ptr        <= rx_shift;
						bus_dat_oe <= (rx_shift < ptr_t'(REG_DEPTH));
						state      <= ST_PTR_ACK;
					end
				ST_PTR_ACK, ST_WR_ACK:
				begin
					state      <= ST_WR_DATA;
					bus_dat_oe <= 1'b0;
				end
				ST_WR_DATA:
					if (byte_done)
					begin
						bit_cnt    <= 4'd0;
						ptr        <= ptr + 8'd1;
						bus_dat_oe <= ptr_ok;
						state      <= ST_WR_ACK;
					end
				ST_RD_DATA:
					if (byte_done)
					begin
						// Release the line for the controller ACK
						bit_cnt    <= 4'd0;
						ptr        <= ptr + 8'd1;
						bus_dat_oe <= 1'b0;
						state      <= ST_RD_ACK;
					end
					else
						bus_dat_oe <= ~tx_shift[7];
				ST_RD_ACK:
					if (host_nack)
					begin
						state      <= ST_IDLE;
						bus_dat_oe <= 1'b0;
					end
					else
					begin
						state      <= ST_RD_DATA;
						bus_dat_oe <= ~rd_byte[7];
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Shift registers, receive on rise and transmit on fall
	always_ff @(posedge scl)
	begin
		if (clk_rise && rx_state)
			rx_shift <= {rx_shift[6:0], dat_s};
		if (clk_fall)
		begin
			if (tx_load)
				tx_shift <= {rd_byte[6:0], 1'b1};
			else if (state == ST_RD_DATA)
				tx_shift <= {tx_shift[6:0], 1'b1};
		end
	end

endmodule

/* verilog/i2c_reg_bank.sv */
/*
 * I2C target register bank
 * Sixteen bytes shared between the I2C engine and a local port.
 * The local port uses a four-phase req/ack handshake and yields
 * to bus writes
 */

`timescale 1ns/1ps

module i2c_reg_bank
	import i2c_tgt_pkg::*;
(
	input  logic     scl,
	input  logic     rst_n,
	input  reg_idx_t bus_idx,
	input  logic     bus_we,
	input  byte_t    bus_wdata,
	output byte_t    bus_rdata,
	input  logic     loc_req,
	input  logic     loc_we,
	input  reg_idx_t loc_idx,
	input  byte_t    loc_wdata,
	output logic     loc_ack,
	output byte_t    loc_rdata
);

	typedef enum logic
	{
		HS_IDLE,
		HS_DONE
	} hs_state_t;

	hs_state_t hs_state;
	byte_t     regs [REG_DEPTH];
	logic      loc_go;

	// Local access proceeds only in a cycle free of bus writes
	assign loc_go = (hs_state == HS_IDLE) && loc_req && !bus_we;

	assign bus_rdata = regs[bus_idx];
	assign loc_ack   = (hs_state == HS_DONE);

	// **************************************************************************
	// Storage
	// **************************************************************************
	always_ff @(posedge scl or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < REG_DEPTH; i++)
				regs[i] <= '0;
		end
		else if (bus_we)
			regs[bus_idx] <= bus_wdata;
		else if (loc_go && loc_we)
			regs[loc_idx] <= loc_wdata;
	end

	// **************************************************************************
	// Local handshake
	// **************************************************************************
	always_ff @(posedge scl or negedge rst_n)
	begin
		if (!rst_n)
			hs_state <= HS_IDLE;
		else
		begin
			case (hs_state)
				HS_IDLE:
					if (loc_go)
						hs_state <= HS_DONE;
				HS_DONE:
					// Hold ack until the requester lets go
					if (!loc_req)
						hs_state <= HS_IDLE;
				default:
					hs_state <= HS_IDLE;
			endcase
		end
	end

	// Read data held until the next local read
	always_ff @(posedge scl)
	begin
		if (loc_go && !loc_we)
			loc_rdata <= regs[loc_idx];
	end

endmodule

/* verilog/i2c_tgt_top.sv */
/*
 * I2C target top level
 * Line synchronizer, protocol engine and register bank of the
 * register-bank I2C peripheral
 */

`timescale 1ns/1ps

module i2c_tgt_top
	import i2c_tgt_pkg::*;
(
	input  logic     scl,
	input  logic     rst_n,
	input  logic     bus_clk,
	input  logic     bus_dat,
	output logic     bus_dat_oe,
	input  logic     loc_req,
	input  logic     loc_we,
	input  reg_idx_t loc_idx,
	input  byte_t    loc_wdata,
	output logic     loc_ack,
	output byte_t    loc_rdata,
	output logic     bus_busy
);

	logic     clk_rise;
	logic     clk_fall;
	logic     start_det;
	logic     stop_det;
	logic     dat_s;
	reg_idx_t bus_idx;
	logic     bus_we;
	byte_t    bus_wdata;
	byte_t    bus_rdata;

	i2c_line_sync i_line_sync
	(
		.scl       (scl),
		.rst_n     (rst_n),
		.bus_clk   (bus_clk),
		.bus_dat   (bus_dat),
		.clk_rise  (clk_rise),
		.clk_fall  (clk_fall),
		.start_det (start_det),
		.stop_det  (stop_det),
		.dat_s     (dat_s)
	);

	i2c_tgt_engine i_engine
	(
		.scl        (scl),
		.rst_n      (rst_n),
		.clk_rise   (clk_rise),
		.clk_fall   (clk_fall),
		.start_det  (start_det),
		.stop_det   (stop_det),
		.dat_s      (dat_s),
		.bus_rdata  (bus_rdata),
		.bus_dat_oe (bus_dat_oe),
		.bus_idx    (bus_idx),
		.bus_we     (bus_we),
		.bus_wdata  (bus_wdata),
		.bus_busy   (bus_busy)
	);

	i2c_reg_bank i_reg_bank
	(
		.scl       (scl),
		.rst_n     (rst_n),
		.bus_idx   (bus_idx),
		.bus_we    (bus_we),
		.bus_wdata (bus_wdata),
		.bus_rdata (bus_rdata),
		.loc_req   (loc_req),
		.loc_we    (loc_we),
		.loc_idx   (loc_idx),
		.loc_wdata (loc_wdata),
		.loc_ack   (loc_ack),
		.loc_rdata (loc_rdata)
	);

endmodule

/* sim/i2c_tgt_props.sv */
/*
 * I2C target bound properties
 * Reset state, the local four-phase handshake and data line driving
 */

`timescale 1ns/1ps

module i2c_tgt_props
	import i2c_tgt_pkg::*;
(
	input logic scl,
	input logic rst_n,
	input logic bus_dat_oe,
	input logic loc_req,
	input logic loc_ack,
	input logic bus_busy
);

	// Outputs stay quiet through reset
	reset_quiet: assert property (@(posedge scl)
		!rst_n |-> !bus_dat_oe && !loc_ack && !bus_busy)
		else $error("outputs active during reset");

	// **************************************************************************
	// Local handshake
	// **************************************************************************
	ack_needs_req: assert property (@(posedge scl) disable iff (!rst_n)
		$rose(loc_ack) |-> $past(loc_req))
		else $error("loc_ack rose without a request");

	ack_holds: assert property (@(posedge scl) disable iff (!rst_n)
		loc_req && loc_ack |=> loc_ack)
		else $error("loc_ack dropped while loc_req was held");

	ack_releases: assert property (@(posedge scl) disable iff (!rst_n)
		!loc_req && loc_ack |=> !loc_ack)
		else $error("loc_ack stayed high after loc_req fell");

	req_holds: assert property (@(posedge scl) disable iff (!rst_n)
		loc_req && !loc_ack |=> loc_req)
		else $error("loc_req dropped before loc_ack");

	// Target lets go of the line once the engine is idle
	idle_released: assert property (@(posedge scl) disable iff (!rst_n)
		!bus_busy |-> !bus_dat_oe)
		else $error("data line pulled while the engine is idle");

endmodule

/* sim/tb_i2c_tgt.sv */
/*
 * I2C target testbench
 * Directed tests through a bit-level I2C controller model and the
 * local four-phase port. The open-drain data line is resolved here
 */

`timescale 1ns/1ps

module tb_i2c_tgt
	import i2c_tgt_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	// scl cycles per bus_clk half period
	localparam int HALF_BIT = 8;
	localparam int HS_LIMIT = 32;
	// 342 data and ACK bits, starts and stops as two bits each, rounded up
	localparam int BUS_BITS = 400;
	localparam int MARGIN_CYCLES = 4000;
	localparam dev_addr_t OTHER_ADDR = 7'h11;

	logic        scl;
	logic        rst_n;
	logic        bus_clk;
	logic        ctl_oe;
	logic        bus_dat;
	logic        bus_dat_oe;
	logic        loc_req;
	logic        loc_we;
	reg_idx_t    loc_idx;
	byte_t       loc_wdata;
	logic        loc_ack;
	byte_t       loc_rdata;
	logic        bus_busy;

	byte_t       model [REG_DEPTH];
	logic [31:0] lfsr_state;
	string       cur_test;
	int          err_count;
	int          test_errs_start;
	int          check_count;
	int          test_count;
	int          failed_tests;

	// Open drain, low if either side pulls
	assign bus_dat = ~(ctl_oe | bus_dat_oe);

	i2c_tgt_top i_dut
	(
		.scl        (scl),
		.rst_n      (rst_n),
		.bus_clk    (bus_clk),
		.bus_dat    (bus_dat),
		.bus_dat_oe (bus_dat_oe),
		.loc_req    (loc_req),
		.loc_we     (loc_we),
		.loc_idx    (loc_idx),
		.loc_wdata  (loc_wdata),
		.loc_ack    (loc_ack),
		.loc_rdata  (loc_rdata),
		.bus_busy   (bus_busy)
	);

	bind i2c_tgt_top i2c_tgt_props i_props
	(
		.scl        (scl),
		.rst_n      (rst_n),
		.bus_dat_oe (bus_dat_oe),
		.loc_req    (loc_req),
		.loc_ack    (loc_ack),
		.bus_busy   (bus_busy)
	);

	always #(CLK_PERIOD / 2) scl = ~scl;

	initial
	begin
		#((BUS_BITS * 16 + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired, the tests did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

	// **************************************************************************
	// Random data, compare and report helpers
	// **************************************************************************

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_step();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h80200003;
		return out;
	endfunction

	function automatic byte_t rand_byte();
		byte_t b;
		b = '0;
		repeat (8)
			b = {b[6:0], lfsr_step()};
		return b;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge scl);
	endtask

	task automatic check_byte(input string what, input byte_t exp, input byte_t act);
		check_count++;
		if (act !== exp)
		begin
			err_count++;
			$display("[ERROR] %s %s: expected %02h, got %02h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_ack(input string what, input bit exp, input bit act);
		check_count++;
		if (act != exp)
		begin
			err_count++;
			$display("[ERROR] %s %s: expected ack %0b, got %0b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_level(input string what, input logic exp, input logic act);
		check_count++;
		if (act !== exp)
		begin
			err_count++;
			$display("[ERROR] %s %s: expected %0b, got %0b", cur_test, what, exp, act);
		end
	endtask

	task automatic report_failure(input string msg);
		err_count++;
		$display("[ERROR] %s: %s", cur_test, msg);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs_start = err_count;
	endtask

	task automatic end_test();
		int n;
		n = err_count - test_errs_start;
		test_count++;
		if (n == 0)
			$display("test %s: ok", cur_test);
		else
		begin
			failed_tests++;
			$display("test %s: failed with %0d errors", cur_test, n);
		end
	endtask

	// **************************************************************************
	// I2C controller model, clock low on entry and exit of every bit
	// **************************************************************************
	task automatic bus_bit(input logic b, output logic rx);
		wait_cycles(2);
		ctl_oe <= ~b;
		wait_cycles(HALF_BIT - 2);
		bus_clk <= 1'b1;
		wait_cycles(HALF_BIT / 2);
		// Sample mid high phase
		@(negedge scl);
		rx = bus_dat;
		wait_cycles(HALF_BIT / 2);
		bus_clk <= 1'b0;
	endtask

	// Works from idle and as a repeated start
	task automatic send_start();
		wait_cycles(2);
		ctl_oe <= 1'b0;
		wait_cycles(HALF_BIT - 2);
		bus_clk <= 1'b1;
		wait_cycles(HALF_BIT);
		ctl_oe <= 1'b1;
		wait_cycles(HALF_BIT);
		bus_clk <= 1'b0;
	endtask

	task automatic send_stop();
		wait_cycles(2);
		ctl_oe <= 1'b1;
		wait_cycles(HALF_BIT - 2);
		bus_clk <= 1'b1;
		wait_cycles(HALF_BIT);
		ctl_oe <= 1'b0;
		wait_cycles(HALF_BIT);
	endtask

	task automatic send_byte(input byte_t data, output bit ack);
		logic  rx;
		byte_t sh;
		sh = data;
		repeat (8)
		begin
			bus_bit(sh[7], rx);
			sh = sh << 1;
		end
		bus_bit(1'b1, rx);
		ack = !rx;
	endtask

	task automatic read_byte(input bit ack, output byte_t data);
		logic rx;
		data = '0;
		repeat (8)
		begin
			bus_bit(1'b1, rx);
			data = {data[6:0], rx};
		end
		bus_bit(!ack, rx);
	endtask

	task automatic open_transfer(input bit rd);
		bit ack;
		send_start();
		send_byte({TGT_ADDR, rd}, ack);
		check_ack("address", 1'b1, ack);
	endtask

	// **************************************************************************
	// Local port, four-phase req/ack
	// **************************************************************************
	task automatic loc_access(input logic we, input reg_idx_t idx, input byte_t wdata,
		output byte_t rdata);
		int n;
		@(posedge scl);
		loc_req   <= 1'b1;
		loc_we    <= we;
		loc_idx   <= idx;
		loc_wdata <= wdata;
		n = 0;
		do
		begin
			@(negedge scl);
			n++;
		end
		while (!loc_ack && n < HS_LIMIT);
		if (!loc_ack)
			report_failure("local request was never acknowledged");
		rdata = loc_rdata;
		@(posedge scl);
		loc_req <= 1'b0;
		n = 0;
		do
		begin
			@(negedge scl);
			n++;
		end
		while (loc_ack && n < HS_LIMIT);
		if (loc_ack)
			report_failure("local acknowledge stayed high after the request dropped");
	endtask

	task automatic loc_write(input reg_idx_t idx, input byte_t data);
		byte_t unused;
		loc_access(1'b1, idx, data, unused);
		model[idx] = data;
	endtask

	task automatic loc_read(input reg_idx_t idx, output byte_t data);
		loc_access(1'b0, idx, 8'h00, data);
	endtask

	task automatic verify_reg(input reg_idx_t idx);
		byte_t d;
		loc_read(idx, d);
		check_byte($sformatf("register %0d", idx), model[idx], d);
	endtask

	// **************************************************************************
	// Directed tests
	// **************************************************************************
	task automatic test_reset_state();
		begin_test("reset_state");
		@(negedge scl);
		check_level("bus_dat_oe", 1'b0, bus_dat_oe);
		check_level("loc_ack", 1'b0, loc_ack);
		check_level("bus_busy", 1'b0, bus_busy);
		for (int i = 0; i < REG_DEPTH; i++)
			verify_reg(reg_idx_t'(i));
		end_test();
	endtask

	task automatic test_address_match();
		bit ack;
		begin_test("address_match");
		send_start();
		send_byte({OTHER_ADDR, 1'b0}, ack);
		check_ack("foreign address", 1'b0, ack);
		send_byte(8'h02, ack);
		check_ack("pointer after foreign address", 1'b0, ack);
		send_byte(rand_byte(), ack);
		check_ack("data after foreign address", 1'b0, ack);
		send_stop();
		for (int i = 0; i < REG_DEPTH; i++)
			verify_reg(reg_idx_t'(i));
		open_transfer(1'b0);
		send_stop();
		end_test();
	endtask

	task automatic test_bus_write();
		bit    ack;
		byte_t b;
		begin_test("bus_write");
		open_transfer(1'b0);
		send_byte(8'd3, ack);
		check_ack("pointer", 1'b1, ack);
		for (int i = 0; i < 6; i++)
		begin
			b = rand_byte();
			send_byte(b, ack);
			check_ack($sformatf("data byte %0d", i), 1'b1, ack);
			model[reg_idx_t'(3 + i)] = b;
		end
		send_stop();
		for (int i = 0; i < 6; i++)
			verify_reg(reg_idx_t'(3 + i));
		end_test();
	endtask

	task automatic test_bus_read();
		bit    ack;
		byte_t got;
		int    high;
		begin_test("bus_read");
		for (int i = 0; i < 5; i++)
			loc_write(reg_idx_t'(10 + i), rand_byte());
		open_transfer(1'b0);
		send_byte(8'd10, ack);
		check_ack("pointer", 1'b1, ack);
		open_transfer(1'b1);
		// Last byte is NACKed to end the read
		for (int i = 0; i < 5; i++)
		begin
			read_byte(i < 4, got);
			check_byte($sformatf("read byte %0d", i), model[reg_idx_t'(10 + i)], got);
		end
		send_stop();
		high = 0;
		repeat (32)
		begin
			@(negedge scl);
			if (bus_dat_oe)
				high++;
		end
		if (high != 0)
			report_failure("target pulled the data line after the read ended");
		check_level("bus_busy after stop", 1'b0, bus_busy);
		end_test();
	endtask

	task automatic test_out_of_range();
		bit    ack;
		byte_t b;
		begin_test("out_of_range");
		open_transfer(1'b0);
		send_byte(8'h20, ack);
		check_ack("pointer 0x20", 1'b0, ack);
		open_transfer(1'b1);
		read_byte(1'b0, b);
		check_byte("read past the bank", 8'hff, b);
		send_stop();
		// Two bytes fit, the rest run past index 15
		open_transfer(1'b0);
		send_byte(8'd14, ack);
		check_ack("pointer 14", 1'b1, ack);
		for (int i = 0; i < 4; i++)
		begin
			b = rand_byte();
			send_byte(b, ack);
			check_ack($sformatf("data at pointer %0d", 14 + i), (14 + i) < 16, ack);
			if (14 + i < 16)
				model[reg_idx_t'(14 + i)] = b;
		end
		send_stop();
		verify_reg(4'd14);
		verify_reg(4'd15);
		verify_reg(4'd0);
		end_test();
	endtask

	task automatic test_concurrent_access();
		bit    ack;
		byte_t bus_b;
		begin_test("concurrent_access");
		fork
			begin
				open_transfer(1'b0);
				send_byte(8'd0, ack);
				check_ack("pointer", 1'b1, ack);
				for (int i = 0; i < 6; i++)
				begin
					bus_b = rand_byte();
					send_byte(bus_b, ack);
					check_ack($sformatf("data byte %0d", i), 1'b1, ack);
					model[reg_idx_t'(i)] = bus_b;
				end
				send_stop();
			end
			begin
				// Spread over the transfer so some land next to bus writes
				for (int i = 0; i < 16; i++)
				begin
					wait_cycles(60);
					loc_write(reg_idx_t'(8 + i % 8), rand_byte());
				end
			end
		join
		for (int i = 0; i < REG_DEPTH; i++)
			verify_reg(reg_idx_t'(i));
		end_test();
	endtask

	// **************************************************************************
	// Main sequence
	// **************************************************************************
	initial
	begin
		scl        = 1'b0;
		rst_n      = 1'b0;
		bus_clk    = 1'b1;
		ctl_oe     = 1'b0;
		loc_req    = 1'b0;
		loc_we     = 1'b0;
		loc_idx    = '0;
		loc_wdata  = '0;
		lfsr_state = 32'hcc02d5aa;
		err_count    = 0;
		check_count  = 0;
		test_count   = 0;
		failed_tests = 0;
		for (int i = 0; i < REG_DEPTH; i++)
			model[reg_idx_t'(i)] = '0;
		wait_cycles(10);
		rst_n <= 1'b1;
		wait_cycles(4);
		test_reset_state();
		test_address_match();
		test_bus_write();
		test_bus_read();
		test_out_of_range();
		test_concurrent_access();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_count, failed_tests, check_count, err_count);
		if (err_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* flist.f */
verilog/i2c_tgt_pkg.sv
verilog/i2c_line_sync.sv
verilog/i2c_tgt_engine.sv
verilog/i2c_reg_bank.sv
verilog/i2c_tgt_top.sv
sim/i2c_tgt_props.sv
sim/tb_i2c_tgt.sv

/* Makefile */
# Verilator build and run of the I2C target testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_tgt
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= === PASS ===

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q -- "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
